// ==== project.f ====
exec_pkg.sv
alu_unit.sv
mul_pipe.sv
div_unit.sv
wb_select.sv
exec_stage.sv
tb_clock.sv
tb_exec.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_exec.sv ====
`timescale 1ns/1ps

module tb_exec
  import exec_pkg::*;
();

  localparam int NUM_CB_ENTRY = 16;
  localparam int IDX_W        = $clog2(NUM_CB_ENTRY);
  localparam int ALU_LAT      = 1;
  localparam int MUL_LAT      = 3;
  localparam int DIV_LAT      = 33;
  localparam int DIV_TIMEOUT  = 40;

  typedef logic [IDX_W-1:0] cb_idx_t;

  // one expected result and the cycles it was issued and is due in
  typedef struct packed {
    logic [31:0] issue_cyc;
    logic [31:0] due_cyc;
    reg_idx_t    rd;
    cb_idx_t     index;
    word_t       wdata;
  } exp_t;

  logic      CLK, nRST;
  logic      issue_valid;
  unit_sel_t issue_unit;
  alu_op_t   alu_op;
  md_op_t    md_op;
  word_t     port_a, port_b;
  reg_idx_t  issue_rd;
  cb_idx_t   issue_index;

  logic     bypass_alu_valid, bypass_mul_valid, bypass_div_valid, div_busy, cb_valid;
  reg_idx_t bypass_alu_rd, bypass_mul_rd, bypass_div_rd, cb_rd;
  cb_idx_t  bypass_alu_index, bypass_mul_index, bypass_div_index, cb_index;
  word_t    bypass_alu_wdata, bypass_mul_wdata, bypass_div_wdata, cb_wdata;

  exp_t        alu_q[$], mul_q[$], div_q[$];
  logic [31:0] cyc;
  logic [31:0] last_due;
  logic [31:0] lfsr_state = 32'h889b_cd3f;
  int          errors, checks, tests_run, tests_failed, test_err_base;
  bit          timed_out;

  tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(2)) clk_gen (.CLK(CLK), .nRST(nRST));

  exec_stage #(.NUM_CB_ENTRY(NUM_CB_ENTRY)) dut0 (
    .CLK(CLK), .nRST(nRST), .issue_valid(issue_valid), .issue_unit(issue_unit),
    .alu_op(alu_op), .md_op(md_op), .port_a(port_a), .port_b(port_b),
    .issue_rd(issue_rd), .issue_index(issue_index),
    .bypass_alu_valid(bypass_alu_valid), .bypass_alu_rd(bypass_alu_rd),
    .bypass_alu_index(bypass_alu_index), .bypass_alu_wdata(bypass_alu_wdata),
    .bypass_mul_valid(bypass_mul_valid), .bypass_mul_rd(bypass_mul_rd),
    .bypass_mul_index(bypass_mul_index), .bypass_mul_wdata(bypass_mul_wdata),
    .bypass_div_valid(bypass_div_valid), .bypass_div_rd(bypass_div_rd),
    .bypass_div_index(bypass_div_index), .bypass_div_wdata(bypass_div_wdata),
    .div_busy(div_busy), .cb_valid(cb_valid), .cb_rd(cb_rd),
    .cb_index(cb_index), .cb_wdata(cb_wdata)
  );

  // rising edges since reset release
  always @(posedge CLK or negedge nRST) begin
    if (!nRST) cyc <= '0;
    else cyc <= cyc + 1;
  end

  // galois lfsr stepped once per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  function automatic word_t ref_divide(input md_op_t op, input word_t a, input word_t b);
    logic  sgn, want_rem;
    word_t q, r;
    sgn      = (op == MD_DIV) || (op == MD_REM);
    want_rem = (op == MD_REM) || (op == MD_REMU);
    if (b == '0) begin
      q = '1;
      r = a;
    end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // signed overflow
      q = a;
      r = '0;
    end else if (sgn) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    return want_rem ? r : q;
  endfunction

  function automatic word_t ref_result(input unit_sel_t unit, input alu_op_t aop,
                                       input md_op_t mop, input word_t a, input word_t b);
    logic signed [63:0] sa, sb, sprod;
    logic [63:0]        uprod;
    word_t              res;
    sa    = {{32{a[31]}}, a};
    sb    = {{32{b[31]}}, b};
    sprod = sa * sb;
    uprod = {32'b0, a} * {32'b0, b};
    res   = '0;
    case (unit)
      UNIT_ALU: begin
        case (aop)
          ALU_ADD: res = a + b;
          ALU_SUB: res = a - b;
          ALU_AND: res = a & b;
          ALU_OR:  res = a | b;
          ALU_XOR: res = a ^ b;
          ALU_SLL: res = a << b[4:0];
          ALU_SRL: res = a >> b[4:0];
          default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
      end
      UNIT_MUL: begin
        if (mop == MD_MULH) res = sprod[63:32];
        else if (mop == MD_MULHU) res = uprod[63:32];
        else res = sprod[31:0];
      end
      UNIT_DIV: res = ref_divide(mop, a, b);
      default:  res = '0;
    endcase
    return res;
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("MISMATCH %s expected %h got %h at cycle %0d", name, exp, act, cyc);
      errors++;
    end
  endtask

  task automatic check_unit(input string name, input bit due, input exp_t e, input logic v,
                            input reg_idx_t rd, input cb_idx_t idx, input word_t wd);
    compare_word({name, "_valid"}, 32'(due), 32'(v));
    if (due) begin
      compare_word({name, "_rd"}, 32'(e.rd), 32'(rd));
      compare_word({name, "_index"}, 32'(e.index), 32'(idx));
      compare_word({name, "_wdata"}, e.wdata, wd);
    end
  endtask

  // each bypass port, div_busy and the merged cb port compared every cycle
  always @(negedge CLK) begin : result_check
    bit   alu_due, mul_due, div_due;
    exp_t alu_e, mul_e, div_e, cb_e;
    logic busy_exp;
    if (nRST) begin
      alu_due  = (alu_q.size() > 0) && (alu_q[0].due_cyc == cyc);
      mul_due  = (mul_q.size() > 0) && (mul_q[0].due_cyc == cyc);
      div_due  = (div_q.size() > 0) && (div_q[0].due_cyc == cyc);
      busy_exp = (div_q.size() > 0) && (cyc > div_q[0].issue_cyc) &&
                 (cyc < div_q[0].due_cyc);
      alu_e = '0;
      mul_e = '0;
      div_e = '0;
      if (alu_due) alu_e = alu_q.pop_front();
      if (mul_due) mul_e = mul_q.pop_front();
      if (div_due) div_e = div_q.pop_front();
      check_unit("bypass_alu", alu_due, alu_e, bypass_alu_valid, bypass_alu_rd,
                 bypass_alu_index, bypass_alu_wdata);
      check_unit("bypass_mul", mul_due, mul_e, bypass_mul_valid, bypass_mul_rd,
                 bypass_mul_index, bypass_mul_wdata);
      check_unit("bypass_div", div_due, div_e, bypass_div_valid, bypass_div_rd,
                 bypass_div_index, bypass_div_wdata);
      compare_word("div_busy", 32'(busy_exp), 32'(div_busy));
      // alu wins over mul, mul over div
      if (alu_due) cb_e = alu_e;
      else if (mul_due) cb_e = mul_e;
      else if (div_due) cb_e = div_e;
      else cb_e = '0;
      compare_word("cb_valid", 32'(alu_due | mul_due | div_due), 32'(cb_valid));
      compare_word("cb_rd", 32'(cb_e.rd), 32'(cb_rd));
      compare_word("cb_index", 32'(cb_e.index), 32'(cb_index));
      compare_word("cb_wdata", cb_e.wdata, cb_wdata);
    end
  end

  // drive one issue on this falling edge and record what it should return
  task automatic issue_op(input unit_sel_t unit, input alu_op_t aop, input md_op_t mop,
                          input word_t a, input word_t b, input reg_idx_t rd,
                          input cb_idx_t idx);
    exp_t e;
    bit   accepted;
    issue_valid = 1'b1;
    issue_unit  = unit;
    alu_op      = aop;
    md_op       = mop;
    port_a      = a;
    port_b      = b;
    issue_rd    = rd;
    issue_index = idx;
    e.issue_cyc = cyc;
    e.rd        = rd;
    e.index     = idx;
    e.wdata     = ref_result(unit, aop, mop, a, b);
    accepted    = 1'b1;
    case (unit)
      UNIT_ALU: begin
        e.due_cyc = cyc + ALU_LAT;
        alu_q.push_back(e);
      end
      UNIT_MUL: begin
        e.due_cyc = cyc + MUL_LAT;
        mul_q.push_back(e);
      end
      default: begin
        // a pending divide means the divider drops this start
        e.due_cyc = cyc + DIV_LAT;
        accepted  = (div_q.size() == 0);
        if (accepted) div_q.push_back(e);
      end
    endcase
    if (accepted && e.due_cyc > last_due) last_due = e.due_cyc;
    @(negedge CLK);
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (cyc <= last_due && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (cyc <= last_due) begin
      $display("timeout: results still outstanding after %0d cycles", limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_div_result(input int limit);
    int n;
    n = 0;
    while (!bypass_div_valid && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (!bypass_div_valid) begin
      $display("timeout: divider gave no result within %0d cycles", limit);
      timed_out = 1'b1;
    end
  endtask

  task automatic end_test(input int num, input string name);
    int errs;
    errs = errors - test_err_base;
    tests_run++;
    if (errs == 0 && !timed_out) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errs);
    end
    test_err_base = errors;
  endtask

  task automatic run_alu_test();
    int       i;
    alu_op_t  op;
    word_t    a, b;
    reg_idx_t rd;
    cb_idx_t  idx;
    for (i = 0; i < 200; i++) begin
      op  = alu_op_t'(rand_bits(3));
      a   = rand_bits(32);
      b   = rand_bits(32);
      rd  = reg_idx_t'(rand_bits(5));
      idx = cb_idx_t'(rand_bits(IDX_W));
      issue_op(UNIT_ALU, op, '0, a, b, rd, idx);
    end
    issue_valid = 1'b0;
    wait_drain(10);
    end_test(2, "alu operations");
  endtask

  task automatic run_mul_test();
    int       i;
    md_op_t   op;
    word_t    a, b;
    reg_idx_t rd;
    cb_idx_t  idx;
    for (i = 0; i < 100; i++) begin
      op  = md_op_t'(rand_bits(2) % 3);
      a   = rand_bits(32);
      b   = rand_bits(32);
      rd  = reg_idx_t'(rand_bits(5));
      idx = cb_idx_t'(rand_bits(IDX_W));
      issue_op(UNIT_MUL, ALU_ADD, op, a, b, rd, idx);
    end
    issue_valid = 1'b0;
    wait_drain(10);
    end_test(3, "multiplier");
  endtask

  task automatic run_div_test();
    int       i;
    md_op_t   op;
    word_t    a, b;
    reg_idx_t rd;
    cb_idx_t  idx;
    for (i = 0; i < 16 && !timed_out; i++) begin
      op = md_op_t'(rand_bits(2));
      a  = rand_bits(32);
      if (rand_bits(1)) b = rand_bits(32);
      else b = rand_bits(6);
      // first divide by zero for every op, then the two overflow cases
      if (i < 4) begin
        op = md_op_t'(i);
        b  = '0;
      end else if (i < 6) begin
        op = (i == 4) ? MD_DIV : MD_REM;
        a  = 32'h8000_0000;
        b  = 32'hffff_ffff;
      end
      rd  = reg_idx_t'(rand_bits(5));
      idx = cb_idx_t'(rand_bits(IDX_W));
      issue_op(UNIT_DIV, ALU_ADD, op, a, b, rd, idx);
      issue_valid = 1'b0;
      wait_div_result(DIV_TIMEOUT);
      @(negedge CLK);
    end
    end_test(4, "divider");
  endtask

  task automatic run_ignored_div_test();
    int n, extra;
    issue_op(UNIT_DIV, ALU_ADD, MD_DIVU, 32'd1000, 32'd7, 5'd3, cb_idx_t'(1));
    issue_valid = 1'b0;
    @(negedge CLK);
    issue_op(UNIT_DIV, ALU_ADD, MD_DIVU, 32'd555, 32'd5, 5'd4, cb_idx_t'(2));
    issue_valid = 1'b0;
    wait_div_result(DIV_TIMEOUT);
    extra = 0;
    for (n = 0; n < DIV_TIMEOUT && !timed_out; n++) begin
      @(negedge CLK);
      if (bypass_div_valid) extra++;
    end
    checks++;
    assert (extra == 0) else begin
      $display("divide issued while busy still produced %0d extra results", extra);
      errors++;
    end
    end_test(5, "ignored divide start");
  endtask

  task automatic run_collision_test();
    int n, cb_n, mul_n;
    issue_op(UNIT_MUL, ALU_ADD, MD_MUL, 32'd1234, 32'd5678, 5'd10, cb_idx_t'(5));
    issue_valid = 1'b0;
    @(negedge CLK);
    // lands in the same cycle as the multiply
    issue_op(UNIT_ALU, ALU_XOR, '0, 32'hdead_0000, 32'h0000_beef, 5'd11, cb_idx_t'(6));
    issue_valid = 1'b0;
    cb_n  = 0;
    mul_n = 0;
    for (n = 0; n < 6; n++) begin
      if (cb_valid) cb_n++;
      if (bypass_mul_valid) mul_n++;
      @(negedge CLK);
    end
    compare_word("cb_valid pulses", 32'd1, 32'(cb_n));
    compare_word("bypass_mul_valid pulses", 32'd1, 32'(mul_n));
    wait_drain(5);
    end_test(6, "collision");
  endtask

  initial begin : stimulus
    int n;
    issue_valid = 1'b0;
    issue_unit  = UNIT_ALU;
    alu_op      = ALU_ADD;
    md_op       = '0;
    port_a      = '0;
    port_b      = '0;
    issue_rd    = '0;
    issue_index = '0;
    last_due    = '0;
    n = 0;
    while (nRST !== 1'b1 && n < 20) begin
      @(negedge CLK);
      n++;
    end
    if (nRST !== 1'b1) begin
      $display("reset was never released");
      timed_out = 1'b1;
    end
    if (!timed_out) begin
      compare_word("bypass_alu_valid", 32'd0, 32'(bypass_alu_valid));
      compare_word("bypass_mul_valid", 32'd0, 32'(bypass_mul_valid));
      compare_word("bypass_div_valid", 32'd0, 32'(bypass_div_valid));
      compare_word("div_busy", 32'd0, 32'(div_busy));
      compare_word("cb_valid", 32'd0, 32'(cb_valid));
      repeat (2) @(negedge CLK);
      end_test(1, "reset state");
    end
    if (!timed_out) run_alu_test();
    if (!timed_out) run_mul_test();
    if (!timed_out) run_div_test();
    if (!timed_out) run_ignored_div_test();
    if (!timed_out) run_collision_test();
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // count rising edges, then let go of reset on the next falling edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST <= 1'b1;
  end

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps

module exec_stage
  import exec_pkg::*;
#(
  parameter int NUM_CB_ENTRY = 16,
  localparam int IDX_W = $clog2(NUM_CB_ENTRY)
) (
  input  logic             CLK,
  input  logic             nRST,
  // issue side
  input  logic             issue_valid,
  input  unit_sel_t        issue_unit,
  input  alu_op_t          alu_op,
  input  md_op_t           md_op,
  input  word_t            port_a,
  input  word_t            port_b,
  input  reg_idx_t         issue_rd,
  input  logic [IDX_W-1:0] issue_index,
  // per-unit bypass
  output logic             bypass_alu_valid,
  output reg_idx_t         bypass_alu_rd,
  output logic [IDX_W-1:0] bypass_alu_index,
  output word_t            bypass_alu_wdata,
  output logic             bypass_mul_valid,
  output reg_idx_t         bypass_mul_rd,
  output logic [IDX_W-1:0] bypass_mul_index,
  output word_t            bypass_mul_wdata,
  output logic             bypass_div_valid,
  output reg_idx_t         bypass_div_rd,
  output logic [IDX_W-1:0] bypass_div_index,
  output word_t            bypass_div_wdata,
  output logic             div_busy,
  // completion buffer write port
  output logic             cb_valid,
  output reg_idx_t         cb_rd,
  output logic [IDX_W-1:0] cb_index,
  output word_t            cb_wdata
);

  logic alu_start, mul_start, div_start;

  // one start strobe per issue, divider only when idle
  assign alu_start = issue_valid && (issue_unit == UNIT_ALU);
  assign mul_start = issue_valid && (issue_unit == UNIT_MUL);
  assign div_start = issue_valid && (issue_unit == UNIT_DIV) && !div_busy;

  alu_unit #(.NUM_CB_ENTRY(NUM_CB_ENTRY)) u_alu (
    .CLK(CLK), .nRST(nRST), .start(alu_start), .op(alu_op),
    .a(port_a), .b(port_b), .rd(issue_rd), .index(issue_index),
    .alu_valid(bypass_alu_valid), .alu_rd(bypass_alu_rd),
    .alu_index(bypass_alu_index), .alu_wdata(bypass_alu_wdata)
  );

  mul_pipe #(.NUM_CB_ENTRY(NUM_CB_ENTRY)) u_mul (
    .CLK(CLK), .nRST(nRST), .start(mul_start), .op(md_op),
    .a(port_a), .b(port_b), .rd(issue_rd), .index(issue_index),
    .mul_valid(bypass_mul_valid), .mul_rd(bypass_mul_rd),
    .mul_index(bypass_mul_index), .mul_wdata(bypass_mul_wdata)
  );

  div_unit #(.NUM_CB_ENTRY(NUM_CB_ENTRY)) u_div (
    .CLK(CLK), .nRST(nRST), .start(div_start), .op(md_op),
    .a(port_a), .b(port_b), .rd(issue_rd), .index(issue_index),
    .div_valid(bypass_div_valid), .div_rd(bypass_div_rd),
    .div_index(bypass_div_index), .div_wdata(bypass_div_wdata),
    .div_busy(div_busy)
  );

  // bypass outputs double as the arbiter inputs
  wb_select #(.NUM_CB_ENTRY(NUM_CB_ENTRY)) u_wb (
    .alu_valid(bypass_alu_valid), .alu_rd(bypass_alu_rd),
    .alu_index(bypass_alu_index), .alu_wdata(bypass_alu_wdata),
    .mul_valid(bypass_mul_valid), .mul_rd(bypass_mul_rd),
    .mul_index(bypass_mul_index), .mul_wdata(bypass_mul_wdata),
    .div_valid(bypass_div_valid), .div_rd(bypass_div_rd),
    .div_index(bypass_div_index), .div_wdata(bypass_div_wdata),
    .cb_valid(cb_valid), .cb_rd(cb_rd),
    .cb_index(cb_index), .cb_wdata(cb_wdata)
  );

endmodule

// ==== wb_select.sv ====
`timescale 1ns/1ps

module wb_select
  import exec_pkg::*;
#(
  parameter int NUM_CB_ENTRY = 16,
  localparam int IDX_W = $clog2(NUM_CB_ENTRY)
) (
  // alu result
  input  logic             alu_valid,
  input  reg_idx_t         alu_rd,
  input  logic [IDX_W-1:0] alu_index,
  input  word_t            alu_wdata,
  // multiplier result
  input  logic             mul_valid,
  input  reg_idx_t         mul_rd,
  input  logic [IDX_W-1:0] mul_index,
  input  word_t            mul_wdata,
  // divider result
  input  logic             div_valid,
  input  reg_idx_t         div_rd,
  input  logic [IDX_W-1:0] div_index,
  input  word_t            div_wdata,
  // completion buffer write port
  output logic             cb_valid,
  output reg_idx_t         cb_rd,
  output logic [IDX_W-1:0] cb_index,
  output word_t            cb_wdata
);

  assign cb_valid = alu_valid | mul_valid | div_valid;

  // fixed priority alu > mul > div
  // a losing result is dropped here but still seen on its bypass port
  always_comb begin
    if (alu_valid) begin
      cb_rd    = alu_rd;
      cb_index = alu_index;
      cb_wdata = alu_wdata;
    end else if (mul_valid) begin
      cb_rd    = mul_rd;
      cb_index = mul_index;
      cb_wdata = mul_wdata;
    end else if (div_valid) begin
      cb_rd    = div_rd;
      cb_index = div_index;
      cb_wdata = div_wdata;
    end else begin
      // idle port carries zeros
      cb_rd    = '0;
      cb_index = '0;
      cb_wdata = {WORD_W{1'b0}};
    end
  end

endmodule

// ==== div_unit.sv ====
`timescale 1ns/1ps

module div_unit
  import exec_pkg::*;
#(
  parameter int NUM_CB_ENTRY = 16,
  localparam int IDX_W = $clog2(NUM_CB_ENTRY)
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  md_op_t           op,
  input  word_t            a,
  input  word_t            b,
  input  reg_idx_t         rd,
  input  logic [IDX_W-1:0] index,
  output logic             div_valid,
  output reg_idx_t         div_rd,
  output logic [IDX_W-1:0] div_index,
  output word_t            div_wdata,
  output logic             div_busy
);

  localparam int CNT_W = $clog2(WORD_W);

  logic             accept;
  logic             is_signed, a_neg, b_neg, b_zero;
  word_t            a_mag, b_mag;

  // iteration state
  word_t            rem_q, quo_q, dsr_q;
  logic [CNT_W-1:0] count;
  logic             neg_q, neg_r, want_rem;

  logic [WORD_W:0]  shifted, trial;
  word_t            rem_next, quo_next;
  word_t            q_final, r_final;

  assign accept    = start & ~div_busy;
  assign is_signed = (op == MD_DIV) || (op == MD_REM);
  assign a_neg     = is_signed & a[WORD_W-1];
  assign b_neg     = is_signed & b[WORD_W-1];
  assign b_zero    = (b == '0);
  assign a_mag     = a_neg ? -a : a;
  assign b_mag     = b_neg ? -b : b;

  // one restoring step: bring in the next dividend bit and try to subtract
  assign shifted  = {rem_q, quo_q[WORD_W-1]};
  assign trial    = shifted - {1'b0, dsr_q};
  assign rem_next = trial[WORD_W] ? shifted[WORD_W-1:0] : trial[WORD_W-1:0];
  assign quo_next = {quo_q[WORD_W-2:0], ~trial[WORD_W]};

  assign q_final = neg_q ? -quo_next : quo_next;
  assign r_final = neg_r ? -rem_next : rem_next;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      div_busy  <= 1'b0;
      div_valid <= 1'b0;
      div_rd    <= '0;
      div_index <= '0;
      div_wdata <= '0;
      rem_q     <= '0;
      quo_q     <= '0;
      dsr_q     <= '0;
      count     <= '0;
      neg_q     <= 1'b0;
      neg_r     <= 1'b0;
      want_rem  <= 1'b0;
    end else begin
      div_valid <= 1'b0;
      if (accept) begin
        div_busy  <= 1'b1;
        div_rd    <= rd;
        div_index <= index;
        rem_q     <= '0;
        quo_q     <= a_mag;
        dsr_q     <= b_mag;
        count     <= '0;
        // divide by zero leaves an all-ones quotient, so no negation there
        neg_q     <= (a_neg ^ b_neg) & ~b_zero;
        neg_r     <= a_neg;
        want_rem  <= (op == MD_REM) || (op == MD_REMU);
      end else if (div_busy) begin
        rem_q <= rem_next;
        quo_q <= quo_next;
        count <= count + 1'b1;
        // last step writes the signed result directly
        if (count == CNT_W'(WORD_W - 1)) begin
          div_busy  <= 1'b0;
          div_valid <= 1'b1;
          div_wdata <= want_rem ? r_final : q_final;
        end
      end
    end
  end

endmodule

// ==== mul_pipe.sv ====
`timescale 1ns/1ps

module mul_pipe
  import exec_pkg::*;
#(
  parameter int NUM_CB_ENTRY = 16,
  localparam int IDX_W = $clog2(NUM_CB_ENTRY)
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  md_op_t           op,
  input  word_t            a,
  input  word_t            b,
  input  reg_idx_t         rd,
  input  logic [IDX_W-1:0] index,
  output logic             mul_valid,
  output reg_idx_t         mul_rd,
  output logic [IDX_W-1:0] mul_index,
  output word_t            mul_wdata
);

  localparam int H  = WORD_W / 2;
  localparam int PW = 2 * WORD_W;

  // operands widened by one bit so signed and unsigned share one multiplier
  logic [WORD_W:0]       a_ext, b_ext;
  logic signed [H:0]     a_lo, a_hi, b_lo, b_hi;
  logic signed [2*H+1:0] pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
  logic [PW-1:0]         prod_q;

  logic             v1, v2;
  reg_idx_t         rd1, rd2;
  logic [IDX_W-1:0] idx1, idx2;
  md_op_t           op1, op2;

  // only mulhu treats both operands as unsigned
  assign a_ext = {(op != MD_MULHU) & a[WORD_W-1], a};
  assign b_ext = {(op != MD_MULHU) & b[WORD_W-1], b};

  assign a_lo = {1'b0, a_ext[H-1:0]};
  assign a_hi = a_ext[WORD_W:H];
  assign b_lo = {1'b0, b_ext[H-1:0]};
  assign b_hi = b_ext[WORD_W:H];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      mul_valid <= 1'b0;
      {rd1, rd2, mul_rd} <= '0;
      {idx1, idx2, mul_index} <= '0;
      {op1, op2} <= '0;
      {pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q} <= '0;
      prod_q <= '0;
      mul_wdata <= '0;
    end else begin
      v1 <= start;
      v2 <= v1;
      mul_valid <= v2;
      // stage 1: partial products over the operand halves
      if (start) begin
        rd1 <= rd;
        idx1 <= index;
        op1 <= op;
        pp_ll_q <= a_lo * b_lo;
        pp_lh_q <= a_lo * b_hi;
        pp_hl_q <= a_hi * b_lo;
        pp_hh_q <= a_hi * b_hi;
      end
      // stage 2: sum into the full product
      if (v1) begin
        rd2 <= rd1;
        idx2 <= idx1;
        op2 <= op1;
        prod_q <= PW'(pp_ll_q) + (PW'(pp_lh_q) << H) + (PW'(pp_hl_q) << H)
                  + (PW'(pp_hh_q) << WORD_W);
      end
      // stage 3: pick the requested half
      if (v2) begin
        mul_rd <= rd2;
        mul_index <= idx2;
        case (op2)
          MD_MUL:             mul_wdata <= prod_q[WORD_W-1:0];
          MD_MULH, MD_MULHU:  mul_wdata <= prod_q[PW-1:WORD_W];
          default:            mul_wdata <= prod_q[WORD_W-1:0];
        endcase
      end
    end
  end

endmodule

// ==== alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit
  import exec_pkg::*;
#(
  parameter int NUM_CB_ENTRY = 16,
  localparam int IDX_W = $clog2(NUM_CB_ENTRY)
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             start,
  input  alu_op_t          op,
  input  word_t            a,
  input  word_t            b,
  input  reg_idx_t         rd,
  input  logic [IDX_W-1:0] index,
  output logic             alu_valid,
  output reg_idx_t         alu_rd,
  output logic [IDX_W-1:0] alu_index,
  output word_t            alu_wdata
);

  localparam int SHAMT_W = $clog2(WORD_W);

  word_t               result;
  logic [SHAMT_W-1:0]  shamt;

  assign shamt = b[SHAMT_W-1:0];

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLL: result = a << shamt;
      ALU_SRL: result = a >> shamt;
      ALU_SLT: result = word_t'($signed(a) < $signed(b));
      default: result = '0;
    endcase
  end

  // valid is just the registered start, so one pulse per issue
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      alu_valid <= 1'b0;
      alu_rd    <= '0;
      alu_index <= '0;
      alu_wdata <= '0;
    end else begin
      alu_valid <= start;
      if (start) begin
        alu_rd    <= rd;
        alu_index <= index;
        alu_wdata <= result;
      end
    end
  end

endmodule

// ==== exec_pkg.sv ====
package exec_pkg;

  // datapath width shared by all units
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [4:0]        reg_idx_t;

  // target unit of an issued operation
  typedef enum logic [1:0] {
    UNIT_ALU = 2'd0,
    UNIT_MUL = 2'd1,
    UNIT_DIV = 2'd2
  } unit_sel_t;

  // single-cycle alu operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_t;

  // multiply and divide share one 2-bit op field
  typedef logic [1:0] md_op_t;

  localparam md_op_t MD_MUL   = 2'd0;
  localparam md_op_t MD_MULH  = 2'd1;
  localparam md_op_t MD_MULHU = 2'd2;

  localparam md_op_t MD_DIV  = 2'd0;
  localparam md_op_t MD_DIVU = 2'd1;
  localparam md_op_t MD_REM  = 2'd2;
  localparam md_op_t MD_REMU = 2'd3;

endpackage
